//--- source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path width in bits
`define RV_XLEN 32

// integer register count, x0 included
`define RV_REG_COUNT 32

// data RAM depth in 32-bit words
`define RV_MEM_WORDS 64

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- source/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;   // data or address word
  typedef logic [4:0]          reg_addr_t; // register index

  // major opcodes that the core keeps
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // compare ops double as branch conditions
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK,  // pc+4 for jumps
    WB_UIMM,  // lui
    WB_PCREL  // auipc
  } wb_sel_e;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    wb_sel_e   wb_sel;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
  } decoded_t;

  // one retired instruction
  typedef struct packed {
    word_t     pc;
    word_t     next_pc;
    reg_addr_t rd;
    word_t     data;
    logic      write;
  } commit_t;

endpackage

//--- source/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  rv_pkg::word_t    instr,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared funct3 map of OP and OP_IMM, alt selects sub/sra
  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec           = '0;  // unknown encodings fall through as no-ops
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.rd        = instr[11:7];
    dec.alu_op    = rv_pkg::ALU_ADD;
    dec.wb_sel    = rv_pkg::WB_ALU;
    case (opcode)
      rv_pkg::OP: begin
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.alu_op    = arith_op(funct3, funct7[5]);
          dec.reg_write = 1'b1;
        end
      end
      rv_pkg::OP_IMM: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.alu_op    = arith_op(funct3, (funct3 == 3'b101) && instr[30]);
        dec.reg_write = 1'b1;
      end
      rv_pkg::LUI: begin
        dec.imm       = imm_u;
        dec.wb_sel    = rv_pkg::WB_UIMM;
        dec.reg_write = 1'b1;
      end
      rv_pkg::AUIPC: begin
        dec.imm       = imm_u;
        dec.wb_sel    = rv_pkg::WB_PCREL;
        dec.reg_write = 1'b1;
      end
      rv_pkg::JAL: begin
        dec.imm       = imm_j;
        dec.wb_sel    = rv_pkg::WB_LINK;
        dec.reg_write = 1'b1;
        dec.is_jal    = 1'b1;
      end
      rv_pkg::JALR: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.wb_sel    = rv_pkg::WB_LINK;
        dec.reg_write = 1'b1;
        dec.is_jalr   = 1'b1;
      end
      rv_pkg::BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = rv_pkg::ALU_EQ;
          3'b001:  dec.alu_op = rv_pkg::ALU_NE;
          3'b100:  dec.alu_op = rv_pkg::ALU_SLT;  // blt
          3'b101:  dec.alu_op = rv_pkg::ALU_GE;
          3'b110:  dec.alu_op = rv_pkg::ALU_SLTU; // bltu
          3'b111:  dec.alu_op = rv_pkg::ALU_GEU;
          default: dec.is_branch = 1'b0;
        endcase
      end
      rv_pkg::LOAD: begin
        if (funct3 == 3'b010) begin  // lw only
          dec.imm       = imm_i;
          dec.use_imm   = 1'b1;
          dec.wb_sel    = rv_pkg::WB_LOAD;
          dec.mem_read  = 1'b1;
          dec.reg_write = 1'b1;
        end
      end
      rv_pkg::STORE: begin
        if (funct3 == 3'b010) begin  // sw only
          dec.imm       = imm_s;
          dec.use_imm   = 1'b1;
          dec.mem_write = 1'b1;
        end
      end
      default: ;
    endcase
    if (!dec.reg_write)
      dec.rd = '0;  // no destination to report
  end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    alu_result
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;

  assign op_a  = rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  // one signed and one unsigned comparator feed every compare op
  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  alu_result = op_a + op_b;  // also load/store address
      rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:  alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv_pkg::ALU_AND:  alu_result = op_a & op_b;
      rv_pkg::ALU_EQ:   alu_result = {{(`RV_XLEN-1){1'b0}}, op_a == op_b};
      rv_pkg::ALU_NE:   alu_result = {{(`RV_XLEN-1){1'b0}}, op_a != op_b};
      rv_pkg::ALU_GE:   alu_result = {{(`RV_XLEN-1){1'b0}}, ~lt_s};
      rv_pkg::ALU_GEU:  alu_result = {{(`RV_XLEN-1){1'b0}}, ~lt_u};
      default:          alu_result = '0;
    endcase
  end

endmodule

//--- source/rv_branch.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_branch (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    next_pc,
  output rv_pkg::word_t    link
);

  logic          cond;
  logic          taken;
  rv_pkg::word_t pc_target;
  rv_pkg::word_t jalr_target;

  // own comparators so branches resolve beside the ALU
  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_EQ:   cond = rs1_data == rs2_data;
      rv_pkg::ALU_NE:   cond = rs1_data != rs2_data;
      rv_pkg::ALU_SLT:  cond = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::ALU_GE:   cond = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::ALU_SLTU: cond = rs1_data < rs2_data;
      rv_pkg::ALU_GEU:  cond = rs1_data >= rs2_data;
      default:          cond = 1'b0;
    endcase
  end

  assign taken       = (dec.is_branch && cond) || dec.is_jal;
  assign pc_target   = pc + dec.imm;
  assign jalr_target = (rs1_data + dec.imm) & ~rv_pkg::word_t'(1); // lsb forced low
  assign link        = pc + rv_pkg::word_t'(4);

  always_comb begin
    if (dec.is_jalr)
      next_pc = jalr_target;
    else if (taken)
      next_pc = pc_target;
    else
      next_pc = link;  // sequential
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (instr_valid) begin
      pc <= next_pc;
    end
  end

endmodule

//--- source/rv_data_mem.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_data_mem #(
  parameter int WORDS = `RV_MEM_WORDS
) (
  input  logic             clk,
  input  logic             instr_valid,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    addr,
  input  rv_pkg::word_t    store_data,
  output rv_pkg::word_t    load_data
);

  localparam int IDX_W = $clog2(WORDS);

  rv_pkg::word_t    mem [WORDS];
  logic [IDX_W-1:0] idx;

  // byte address to word index, upper bits wrap
  assign idx = addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (instr_valid && dec.mem_write) begin
      mem[idx] <= store_data;
    end
  end

  // async read, quiet unless a load is decoded
  assign load_data = dec.mem_read ? mem[idx] : '0;

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    load_data,
  input  rv_pkg::word_t    link,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    next_pc,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  output rv_pkg::commit_t  commit,
  output logic             commit_valid
);

  rv_pkg::word_t regs [`RV_REG_COUNT];
  rv_pkg::word_t wb_data;

  // x0 reads as zero
  assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

  always_comb begin
    case (dec.wb_sel)
      rv_pkg::WB_LOAD:  wb_data = load_data;
      rv_pkg::WB_LINK:  wb_data = link;
      rv_pkg::WB_UIMM:  wb_data = dec.imm;
      rv_pkg::WB_PCREL: wb_data = pc + dec.imm;
      default:          wb_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (instr_valid && dec.reg_write && dec.rd != '0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  // commit record, same edge as the write
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      commit.pc      <= pc;
      commit.next_pc <= next_pc;
      commit.rd      <= dec.rd;
      commit.data    <= dec.reg_write ? wb_data : '0;
      commit.write   <= dec.reg_write;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= instr_valid;  // one pulse per retired instruction
    end
  end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::word_t   instr,
  input  logic            instr_valid,
  output rv_pkg::word_t   pc,
  output rv_pkg::commit_t commit,
  output logic            commit_valid
);

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    link;
  rv_pkg::word_t    load_data;

  rv_decoder decoder0 (
    .instr (instr),
    .dec   (dec)
  );

  // arithmetic path
  rv_alu alu0 (
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result)
  );

  // control-flow path, alongside the alu
  rv_branch branch0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .dec         (dec),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .pc          (pc),
    .next_pc     (next_pc),
    .link        (link)
  );

  rv_data_mem data_mem0 (
    .clk         (clk),
    .instr_valid (instr_valid),
    .dec         (dec),
    .addr        (alu_result),
    .store_data  (rs2_data),
    .load_data   (load_data)
  );

  rv_regfile regfile0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .dec          (dec),
    .alu_result   (alu_result),
    .load_data    (load_data),
    .link         (link),
    .pc           (pc),
    .next_pc      (next_pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .commit       (commit),
    .commit_valid (commit_valid)
  );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset low over a few rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- verification/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core_tb;

  localparam int FIELDS    = 5;  // instr, rd, write, data, next_pc
  localparam int IDX_W     = 8;
  localparam int SLOTS     = 1 << IDX_W;
  localparam int MAX_LINES = SLOTS / FIELDS;

  logic            clk;
  logic            rst_n;
  rv_pkg::word_t   instr;
  logic            instr_valid;
  rv_pkg::word_t   pc;
  rv_pkg::commit_t commit;
  logic            commit_valid;

  rv_pkg::word_t stim [SLOTS];
  int            num_lines;
  int            value_errors;
  int            protocol_errors;
  int            cycles;
  int            cycle_limit;
  logic [31:0]   rng_state;
  rv_pkg::word_t exp_pc;  // address the core should ask for next

  tb_clock #(
    .PERIOD       (100),
    .RESET_CYCLES (3)
  ) clock0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .pc           (pc),
    .commit       (commit),
    .commit_valid (commit_valid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // marker for slots that the file leaves untouched
  function automatic rv_pkg::word_t fill_word(input logic [IDX_W-1:0] idx);
    return {24'hdead00, idx};
  endfunction

  function automatic rv_pkg::word_t field(input int line, input int col);
    logic [IDX_W-1:0] idx;
    idx = IDX_W'(line * FIELDS + col);
    return stim[idx];
  endfunction

  function automatic int count_lines();
    int n;
    n = 0;
    while (n < MAX_LINES && field(n, 0) != fill_word(IDX_W'(n * FIELDS)))
      n++;
    return n;
  endfunction

  task automatic check_word(input string name, input rv_pkg::word_t actual,
                            input rv_pkg::word_t expected);
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_reg(input string name, input rv_pkg::reg_addr_t actual,
                           input rv_pkg::reg_addr_t expected);
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s expected x%0d actual x%0d",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b",
               $time, name, expected, actual);
    end
  endtask

  // a cycle without a strobe leaves pc alone and commits nothing
  task automatic idle_cycle();
    @(negedge clk);
    if (commit_valid !== 1'b0) begin
      protocol_errors++;
      $display("unexpected commit strobe at %0t ns with no instruction sent", $time);
    end
    check_word("pc", pc, exp_pc);
  endtask

  task automatic run_line(input int n);
    rv_pkg::word_t exp_next;
    rv_pkg::word_t flags;
    exp_next    = field(n, 4);
    flags       = field(n, 2);
    instr       = field(n, 0);
    instr_valid = 1'b1;
    @(negedge clk);
    instr       = '0;
    instr_valid = 1'b0;
    if (commit_valid !== 1'b1) begin
      protocol_errors++;
      $display("missing commit strobe for stimulus line %0d at %0t ns", n, $time);
    end else begin
      check_word("commit.pc", commit.pc, exp_pc);
      check_word("commit.next_pc", commit.next_pc, exp_next);
      check_reg("commit.rd", commit.rd, rv_pkg::reg_addr_t'(field(n, 1)));
      check_bit("commit.write", commit.write, flags[0]);
      check_word("commit.data", commit.data, field(n, 3));
    end
    check_word("pc", pc, exp_next);
    exp_pc = exp_next;
  endtask

  // run limit, sized from the stimulus length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int idle;
    instr           = '0;
    instr_valid     = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    cycles          = 0;
    cycle_limit     = 0;
    rng_state       = 32'hcfba;
    exp_pc          = `RV_RESET_PC;
    for (int i = 0; i < SLOTS; i++)
      stim[IDX_W'(i)] = fill_word(IDX_W'(i));
    $readmemh("verification/rv_stimulus.txt", stim);
    num_lines   = count_lines();
    cycle_limit = num_lines * 5 + 20;
    if (num_lines == 0) begin
      protocol_errors++;
      $display("no instruction lines found in the stimulus file");
    end
    @(posedge rst_n);
    idle_cycle();  // reset pc, no commit yet
    for (int n = 0; n < num_lines; n++) begin
      rng_state = xorshift32(rng_state);
      idle      = int'(rng_state & 32'd3);
      repeat (idle) idle_cycle();
      run_line(n);
    end
    idle_cycle();  // strobe drops after the last one
    $display("done: %0d instructions, %0d value errors, %0d protocol errors",
             num_lines, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verification/rv_stimulus.txt
// columns: instr rd write data next_pc, all hex
// commit pc of each line is the next_pc of the line before, starting at 0
00500093 01 1 00000005 00000004 // addi x1, x0, 5
FFD00113 02 1 FFFFFFFD 00000008 // addi x2, x0, -3
123451B7 03 1 12345000 0000000C // lui x3, 0x12345
00001217 04 1 0000100C 00000010 // auipc x4, 1
002082B3 05 1 00000002 00000014 // add x5, x1, x2
40208333 06 1 00000008 00000018 // sub x6, x1, x2
001123B3 07 1 00000001 0000001C // slt x7, x2, x1
00113433 08 1 00000000 00000020 // sltu x8, x2, x1
0011C4B3 09 1 12345005 00000024 // xor x9, x3, x1
0021E533 0A 1 FFFFFFFD 00000028 // or x10, x3, x2
0021F5B3 0B 1 12345000 0000002C // and x11, x3, x2
00119633 0C 1 468A0000 00000030 // sll x12, x3, x1
001156B3 0D 1 07FFFFFF 00000034 // srl x13, x2, x1
40115733 0E 1 FFFFFFFF 00000038 // sra x14, x2, x1
00309793 0F 1 00000028 0000003C // slli x15, x1, 3
40115813 10 1 FFFFFFFE 00000040 // srai x16, x2, 1
00302023 00 0 00000000 00000044 // sw x3, 0(x0)
00A02423 00 0 00000000 00000048 // sw x10, 8(x0)
10C02223 00 0 00000000 0000004C // sw x12, 260(x0), word 65 wraps to 1
00002903 12 1 12345000 00000050 // lw x18, 0(x0)
00802983 13 1 FFFFFFFD 00000054 // lw x19, 8(x0)
00402A03 14 1 468A0000 00000058 // lw x20, 4(x0)
00108863 00 0 00000000 00000068 // beq x1, x1, +16
00208863 00 0 00000000 0000006C // beq x1, x2, +16
00209863 00 0 00000000 0000007C // bne x1, x2, +16
00109863 00 0 00000000 00000080 // bne x1, x1, +16
00114863 00 0 00000000 00000090 // blt x2, x1, +16
0020C863 00 0 00000000 00000094 // blt x1, x2, +16
FE20DCE3 00 0 00000000 0000008C // bge x1, x2, -8
00115863 00 0 00000000 00000090 // bge x2, x1, +16
0020E863 00 0 00000000 000000A0 // bltu x1, x2, +16
00116863 00 0 00000000 000000A4 // bltu x2, x1, +16
00117863 00 0 00000000 000000B4 // bgeu x2, x1, +16
0020F863 00 0 00000000 000000B8 // bgeu x1, x2, +16
02000B6F 16 1 000000BC 000000D8 // jal x22, +32
10008BE7 17 1 000000DC 00000104 // jalr x23, 0x100(x1), lsb cleared
00708013 00 1 0000000C 00000108 // addi x0, x1, 7
00100C33 18 1 00000005 0000010C // add x24, x0, x1

//--- project.f
+incdir+source
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_branch.sv
source/rv_data_mem.sv
source/rv_regfile.sv
source/rv_core.sv
verification/tb_clock.sv
verification/rv_core_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = rv_core_tb
FILELIST = project.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) source/rv_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
